// File: src/tag_array_pkg.sv
// Tag array shared definitions
// Array dimensions, entry and lane-mask types, controller states
package tag_array_pkg;

  // Index width, 512 entries
  localparam int ADDR_BITS = 9;

  // Each entry is two 26-bit lanes
  localparam int LANE_BITS = 26;
  localparam int LANES     = 2;

  localparam int DEPTH = 1 << ADDR_BITS;

  // Entry index
  typedef logic [ADDR_BITS-1:0] addr_t;

  // Full entry, lane 1 in the upper half
  typedef logic [LANES*LANE_BITS-1:0] entry_t;

  // Per-lane write mask, active high
  typedef logic [LANES-1:0] lane_mask_t;

  // Clearing sweep, then serving requests
  typedef enum logic {
    ST_SWEEP,
    ST_READY
  } ctrl_state_e;

endpackage

// File: src/sram_if.sv
// Single-port SRAM bus
// Active-low controls, address, write data and read data
`timescale 1ns/1ns

interface sram_if;
  import tag_array_pkg::*;

  // Chip enable and global write enable, active low
  logic   cen;
  logic   gwen;

  // Per-bit write enable, active low
  // Only the top bit of each lane is decoded
  entry_t wen;

  addr_t  a;
  entry_t d;

  // Registered read data
  entry_t q;

  // Controller side
  modport ctrl (
    output cen, gwen, wen, a, d,
    input  q
  );

  // RAM side
  modport ram (
    input  cen, gwen, wen, a, d,
    output q
  );

endinterface

// File: src/fpga_ram.sv
// Generic single-port synchronous RAM
// Registered read every cycle, read-first on write
`timescale 1ns/1ns

module fpga_ram #(
  parameter int DATA_WIDTH = 26,
  parameter int ADDR_WIDTH = 9
) (
  input  logic                  CLK,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  we,
  output logic [DATA_WIDTH-1:0] dout
);

  localparam int WORDS = 1 << ADDR_WIDTH;

  // Storage array
  logic [DATA_WIDTH-1:0] ram [0:WORDS-1];

  // Write on we
  // Old contents come out in the write cycle
  always_ff @(posedge CLK) begin
    if (we) begin
      ram[addr] <= din;
    end
    dout <= ram[addr];
  end

endmodule

// File: src/spsram_512x52.sv
// 512x52 single-port SRAM wrapper
// Two 26-bit lanes, active-low enables, address held while idle
`timescale 1ns/1ns

module spsram_512x52 #(
  parameter int ADDR_WIDTH = 9,
  parameter int WRAP_SIZE  = 26
) (
  input  logic CLK,
  sram_if.ram  mem
);
  import tag_array_pkg::*;

  // Address of the last enabled access
  logic [ADDR_WIDTH-1:0] addr_hold;

  // Address seen by both lane RAMs
  logic [ADDR_WIDTH-1:0] ram_addr;

  // Lane outputs, lane 1 upper
  logic [LANES-1:0][WRAP_SIZE-1:0] lane_q;

  // Capture address on every enabled cycle
  always_ff @(posedge CLK) begin
    if (!mem.cen) begin
      addr_hold <= mem.a;
    end
  end

  // Idle cycles reread the held address
  // so the read output does not move
  assign ram_addr = mem.cen ? addr_hold : mem.a;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic                 lane_we;
    logic [WRAP_SIZE-1:0] lane_din;

    // Lane write from chip enable, global enable and the lane's top wen bit
    assign lane_we  = !mem.cen && !mem.gwen && !mem.wen[(i+1)*WRAP_SIZE-1];
    assign lane_din = mem.d[i*WRAP_SIZE +: WRAP_SIZE];

    fpga_ram #(
      .DATA_WIDTH (WRAP_SIZE),
      .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
      .CLK  (CLK),
      .addr (ram_addr),
      .din  (lane_din),
      .we   (lane_we),
      .dout (lane_q[i])
    );
  end

  // Join lanes back into one entry
  assign mem.q = lane_q;

endmodule

// File: src/sweep_counter.sv
// Sweep index counter
// Walks every entry once per start pulse, flags the last index
`timescale 1ns/1ns

module sweep_counter (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 start,
  output tag_array_pkg::addr_t index,
  output logic                 active,
  output logic                 last
);
  import tag_array_pkg::*;

  // Top index of the array
  localparam addr_t LAST_INDEX = addr_t'(DEPTH - 1);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      index  <= '0;
      active <= 1'b0;
    end else if (start) begin
      // Restart from index 0
      index  <= '0;
      active <= 1'b1;
    end else if (active) begin
      // Wraps to 0 after the last index
      index <= index + 1'b1;
      if (last) begin
        active <= 1'b0;
      end
    end
  end

  // Last entry of a running sweep
  assign last = active && (index == LAST_INDEX);

endmodule

// File: src/array_ctrl_fsm.sv
// Tag array controller
// Sequences clearing sweeps and requests onto the SRAM bus
`timescale 1ns/1ns

module array_ctrl_fsm (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     req,
  input  logic                     req_write,
  input  tag_array_pkg::addr_t     req_addr,
  input  tag_array_pkg::lane_mask_t req_mask,
  input  tag_array_pkg::entry_t    req_wdata,
  input  logic                     flush,
  input  tag_array_pkg::addr_t     sweep_index,
  input  logic                     sweep_active,
  input  logic                     sweep_last,
  output logic                     sweep_start,
  output logic                     ready,
  output logic                     rdata_valid,
  sram_if.ctrl                     mem
);
  import tag_array_pkg::*;

  ctrl_state_e state;

  // Set by reset, asks for the first sweep
  logic start_pend;

  // Zero write at the sweep index
  logic sweep_wr;

  // Request taken this cycle, flush wins
  logic accept;
  logic wr_accept;

  // Active-low lane enables
  entry_t lane_wen;

  assign ready     = (state == ST_READY);
  assign accept    = ready && req && !flush;
  assign wr_accept = accept && req_write;
  assign sweep_wr  = (state == ST_SWEEP) && sweep_active;

  // Sweep after reset or on an accepted flush
  assign sweep_start = start_pend || (ready && flush);

  // Expand the lane mask, all lanes during a sweep
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_wen[i*LANE_BITS +: LANE_BITS] =
        {LANE_BITS{!(sweep_wr || (wr_accept && req_mask[i]))}};
    end
  end

  // SRAM controls
  assign mem.cen  = !(sweep_wr || accept);
  assign mem.gwen = !(sweep_wr || wr_accept);
  assign mem.wen  = lane_wen;
  assign mem.a    = sweep_wr ? sweep_index : req_addr;
  assign mem.d    = sweep_wr ? '0 : req_wdata;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state       <= ST_SWEEP;
      start_pend  <= 1'b1;
      rdata_valid <= 1'b0;
    end else begin
      start_pend  <= 1'b0;
      // Read data lands one cycle after accept
      rdata_valid <= accept && !req_write;
      case (state)
        ST_SWEEP: begin
          // Index 511 written on this edge
          if (sweep_active && sweep_last) begin
            state <= ST_READY;
          end
        end
        ST_READY: begin
          if (flush) begin
            state <= ST_SWEEP;
          end
        end
        default: state <= ST_SWEEP;
      endcase
    end
  end

endmodule

// File: src/tag_array_top.sv
// Tag array top level
// 512x52 tag storage with clearing sweep and strobe requests
`timescale 1ns/1ns

module tag_array_top #(
  parameter int ADDR_WIDTH = tag_array_pkg::ADDR_BITS,
  parameter int WRAP_SIZE  = tag_array_pkg::LANE_BITS
) (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  logic                      req,
  input  logic                      req_write,
  input  tag_array_pkg::addr_t      req_addr,
  input  tag_array_pkg::lane_mask_t req_mask,
  input  tag_array_pkg::entry_t     req_wdata,
  input  logic                      flush,
  output logic                      ready,
  output tag_array_pkg::entry_t     rdata,
  output logic                      rdata_valid
);
  import tag_array_pkg::*;

  // Counter link
  logic  sweep_start;
  addr_t sweep_index;
  logic  sweep_active;
  logic  sweep_last;

  // Controller to SRAM bus
  sram_if u_sram_if ();

  sweep_counter u_sweep (
    .CLK    (CLK),
    .arst_n (arst_n),
    .start  (sweep_start),
    .index  (sweep_index),
    .active (sweep_active),
    .last   (sweep_last)
  );

  array_ctrl_fsm u_ctrl (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .req          (req),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_mask     (req_mask),
    .req_wdata    (req_wdata),
    .flush        (flush),
    .sweep_index  (sweep_index),
    .sweep_active (sweep_active),
    .sweep_last   (sweep_last),
    .sweep_start  (sweep_start),
    .ready        (ready),
    .rdata_valid  (rdata_valid),
    .mem          (u_sram_if.ctrl)
  );

  spsram_512x52 #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .WRAP_SIZE  (WRAP_SIZE)
  ) u_sram (
    .CLK (CLK),
    .mem (u_sram_if.ram)
  );

  // Read data straight from the SRAM output
  assign rdata = u_sram_if.q;

endmodule

// File: sim/tag_array_tb.sv
// Tag array testbench
// Replays the cases file against the tag array and checks read data and strobes
`timescale 1ns/1ns

module tag_array_tb;
  import tag_array_pkg::*;

  // Cycle limits, one per kind of wait
  localparam int READY_LIMIT = 2000;
  localparam int VALID_LIMIT = 8;

  logic       CLK;
  logic       arst_n;
  logic       req;
  logic       req_write;
  addr_t      req_addr;
  lane_mask_t req_mask;
  entry_t     req_wdata;
  logic       flush;
  logic       ready;
  entry_t     rdata;
  logic       rdata_valid;

  // Idle gap generator state
  integer seed;
  int     cases_run;

  tag_array_top dut (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .req         (req),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_mask    (req_mask),
    .req_wdata   (req_wdata),
    .flush       (flush),
    .ready       (ready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic check_entry(input string name, input entry_t expected, input entry_t actual);
    if (actual !== expected) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s expected %b actual %b", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Poll ready on falling edges
  task automatic wait_ready(input string name);
    int cycles;
    cycles = 0;
    while (ready !== 1'b1) begin
      if (cycles >= READY_LIMIT) begin
        $display("%s: ready never rose within %0d cycles", name, READY_LIMIT);
        $display("Simulation FAILED");
        $fatal(1);
      end
      @(negedge CLK);
      cycles++;
    end
  endtask

  // Entered one cycle after the request edge
  task automatic wait_valid(input string name, output int cycles);
    cycles = 1;
    while (rdata_valid !== 1'b1) begin
      if (cycles >= VALID_LIMIT) begin
        $display("%s: rdata_valid never pulsed after a read request", name);
        $display("Simulation FAILED");
        $fatal(1);
      end
      @(negedge CLK);
      cycles++;
    end
  endtask

  // One-cycle request strobe, starting on a falling edge
  task automatic issue_request(input logic write, input addr_t addr, input lane_mask_t mask,
                               input entry_t data);
    req       = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_mask  = mask;
    req_wdata = data;
    @(negedge CLK);
    req       = 1'b0;
    req_write = 1'b0;
  endtask

  task automatic idle_gap();
    int gap;
    gap = $random(seed) & 32'h3;
    repeat (gap) @(negedge CLK);
  endtask

  task automatic run_write(input string name, input addr_t addr, input lane_mask_t mask,
                           input entry_t data);
    wait_ready(name);
    issue_request(1'b1, addr, mask, data);
    // Writes raise no read strobe
    check_bit({name, " rdata_valid"}, 1'b0, rdata_valid);
  endtask

  task automatic run_read(input string name, input addr_t addr, input entry_t expected);
    int cycles;
    wait_ready(name);
    issue_request(1'b0, addr, '0, '0);
    wait_valid(name, cycles);
    // Strobe due in the cycle right after accept
    check_bit({name, " valid next cycle"}, 1'b1, cycles == 1);
    check_entry(name, expected, rdata);
  endtask

  // Read data must not move across idle cycles
  // Idle address wanders off, only the held one may reach the RAM
  task automatic run_hold(input string name, input int count, input entry_t expected);
    repeat (count) begin
      req_addr = req_addr + 1'b1;
      @(negedge CLK);
      check_entry({name, " held rdata"}, expected, rdata);
      check_bit({name, " rdata_valid"}, 1'b0, rdata_valid);
    end
  endtask

  task automatic run_flush(input string name, input addr_t addr, input lane_mask_t mask,
                           input entry_t data);
    wait_ready(name);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    check_bit({name, " ready low"}, 1'b0, ready);
    // Both requests land mid-sweep and must be dropped
    issue_request(1'b1, addr, mask, data);
    issue_request(1'b0, addr, '0, '0);
    repeat (2) begin
      check_bit({name, " ignored read"}, 1'b0, rdata_valid);
      @(negedge CLK);
    end
    wait_ready(name);
  endtask

  initial begin
    string      line;
    string      name;
    integer     fd;
    int         lineno;
    int         count;
    logic [7:0] op;
    addr_t      addr;
    lane_mask_t mask;
    entry_t     data;
    entry_t     expected;

    seed      = 32'h5b8c3de8;
    cases_run = 0;
    lineno    = 0;
    arst_n    = 1'b0;
    req       = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_mask  = '0;
    req_wdata = '0;
    flush     = 1'b0;

    // Reset for 4 cycles
    repeat (4) @(negedge CLK);
    check_bit("reset ready", 1'b0, ready);
    check_bit("reset rdata_valid", 1'b0, rdata_valid);
    arst_n = 1'b1;
    @(negedge CLK);
    // Clearing sweep under way
    check_bit("sweep ready", 1'b0, ready);

    fd = $fopen("sim/tag_array_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/tag_array_cases.txt");
      $display("Simulation FAILED");
      $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
      lineno++;
      count = $sscanf(line, "%s %h %h %h %h", op, addr, mask, data, expected);
      // Comment and blank lines fail to parse
      if (count == 5) begin
        name = $sformatf("line %0d op %s", lineno, op);
        case (op)
          "W": run_write(name, addr, mask, data);
          "R": run_read(name, addr, expected);
          "H": run_hold(name, int'(addr), expected);
          "F": run_flush(name, addr, mask, data);
          default: begin
            $display("%s: unknown operation in the cases file", name);
            $display("Simulation FAILED");
            $fatal(1);
          end
        endcase
        cases_run++;
        idle_gap();
      end
    end
    $fclose(fd);

    if (cases_run == 0) begin
      $display("no operations were read from the cases file");
      $display("Simulation FAILED");
      $fatal(1);
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: sim/tag_array_cases.txt
# op index mask wdata expect, all hex, lane 0 is the low 26 bits
# op is W write, R read, H hold for index cycles, F flush with ignored requests at index
R 000 0 0000000000000 0000000000000
R 1ff 0 0000000000000 0000000000000
R 0a5 0 0000000000000 0000000000000
W 010 3 0123456789abc 0000000000000
R 010 0 0000000000000 0123456789abc
W 1ff 3 fffffffffffff 0000000000000
R 1ff 0 0000000000000 fffffffffffff
W 020 3 aaaaaaaaaaaaa 0000000000000
W 020 1 5555555555555 0000000000000
R 020 0 0000000000000 aaaaaa9555555
W 020 2 0123456789abc 0000000000000
R 020 0 0000000000000 0123455555555
H 005 0 0000000000000 0123455555555
R 010 0 0000000000000 0123456789abc
F 010 3 fffffffffffff 0000000000000
R 010 0 0000000000000 0000000000000
R 020 0 0000000000000 0000000000000
R 1ff 0 0000000000000 0000000000000

// File: tb.f
src/tag_array_pkg.sv
src/sram_if.sv
src/fpga_ram.sv
src/spsram_512x52.sv
src/sweep_counter.sv
src/array_ctrl_fsm.sv
src/tag_array_top.sv
sim/tag_array_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the tag array testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tag_array_tb

# A failing run exits non-zero, so keep its output for the search below
out=$(./obj_dir/Vtag_array_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
